/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_trace_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
source/trace_pkg.sv
source/trace_cfg_if.sv
source/trace_regs.sv
source/pattern_matcher.sv
source/event_capture.sv
source/event_fifo.sv
source/trigger_pulse.sv
source/trace_top.sv
verif/tb_trace_top.sv

/* source/event_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module event_capture import trace_pkg::*; (
  input  logic                 fe_clk,
  input  logic                 reset,
  input  logic [num_rules-1:0] match,
  input  logic                 byte_seen,
  trace_cfg_if.capture         cfg,
  output logic                 ev_write,
  output event_t               ev_data
);

  logic [7:0] stamp;   // bytes since arm modulo 256

  // byte_seen leads match by a cycle, so stamp already counts the matching byte
  always_ff @(posedge fe_clk) begin
    if (reset)
      stamp <= 8'h00;
    else if (cfg.arm_pulse)
      stamp <= 8'h00;
    else if (byte_seen)
      stamp <= stamp + 8'd1;
  end

  always_ff @(posedge fe_clk) begin
    if (reset)
      ev_write <= 1'b0;
    else
      ev_write <= cfg.armed && (match != '0);
  end

  always_ff @(posedge fe_clk) begin
    ev_data.pad   <= '0;
    ev_data.rules <= match;
    ev_data.stamp <= stamp;
  end

endmodule

`default_nettype wire

/* source/event_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module event_fifo import trace_pkg::*; (
  input  logic   fe_clk,
  input  logic   reset,
  input  logic   ev_write,
  input  event_t ev_data,
  input  logic   pop,
  input  logic   clear_overflow,
  output event_t head,
  output logic   empty,
  output logic   full,
  output logic   overflow
);

  event_t                   mem [fifo_depth];
  logic [fifo_addr_width:0] wr_ptr;   // extra msb tells full from empty
  logic [fifo_addr_width:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[fifo_addr_width] != rd_ptr[fifo_addr_width]) &&
                 (wr_ptr[fifo_addr_width-1:0] == rd_ptr[fifo_addr_width-1:0]);
  assign head  = mem[rd_ptr[fifo_addr_width-1:0]];

  always_ff @(posedge fe_clk) begin
    if (ev_write && !full)
      mem[wr_ptr[fifo_addr_width-1:0]] <= ev_data;
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (clear_overflow)
        overflow <= 1'b0;
      if (ev_write && full)
        overflow <= 1'b1;   // event dropped
      else if (ev_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  a_no_pop_empty: assert property (
    @(posedge fe_clk) disable iff (reset) !(pop && empty));

endmodule

`default_nettype wire

/* source/pattern_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher import trace_pkg::*; (
  input  logic                 fe_clk,
  input  logic                 reset,
  input  logic [7:0]           trace_data,
  input  logic                 trace_valid,
  trace_cfg_if.matcher         cfg,
  output logic [num_rules-1:0] match,
  output logic                 byte_seen,
  output logic [7:0]           match_count [num_rules]
);

  logic [buf_width-1:0] trace_buf;   // byte 0 is the newest
  logic [num_rules-1:0] hit;

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      trace_buf <= '0;
      byte_seen <= 1'b0;
    end else begin
      byte_seen <= trace_valid;
      if (trace_valid)
        trace_buf <= {trace_buf[buf_width-9:0], trace_data};
    end
  end

  // masked compare against the freshly shifted buffer
  always_comb begin
    for (int r = 0; r < num_rules; r++)
      hit[r] = cfg.rule_en[r] && (((trace_buf ^ cfg.pattern[r]) & cfg.mask[r]) == '0);
  end

  always_ff @(posedge fe_clk) begin
    if (reset)
      match <= '0;
    else
      match <= byte_seen ? hit : '0;   // one cycle per byte
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      for (int r = 0; r < num_rules; r++)
        match_count[r] <= 8'h00;
    end else begin
      for (int r = 0; r < num_rules; r++)
        if (match[r] && match_count[r] != 8'hff)
          match_count[r] <= match_count[r] + 8'd1;
    end
  end

  for (genvar r = 0; r < num_rules; r++) begin : g_sat_check
    // saturated counters stay put until reset
    a_count_sat: assert property (
      @(posedge fe_clk) disable iff (reset)
      match_count[r] == 8'hff |=> match_count[r] == 8'hff);
  end

endmodule

`default_nettype wire

/* source/trace_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface trace_cfg_if import trace_pkg::*; ();

  logic [buf_width-1:0] pattern [num_rules];
  logic [buf_width-1:0] mask    [num_rules];
  logic [num_rules-1:0] rule_en;
  logic [num_rules-1:0] trig_en;
  logic                 armed;
  logic                 arm_pulse;   // single cycle after ctrl write
  logic [7:0]           trig_delay;
  logic [7:0]           trig_width;

  modport regs (output pattern, mask, rule_en, trig_en, armed, arm_pulse,
                       trig_delay, trig_width);
  modport matcher (input pattern, mask, rule_en);
  modport capture (input armed, arm_pulse);
  modport trigger (input armed, trig_en, trig_delay, trig_width);

endinterface

`default_nettype wire

/* source/trace_pkg.sv */
`default_nettype none

package trace_pkg;

  localparam int num_rules       = 2;
  localparam int buf_bytes       = 4;
  localparam int buf_width       = buf_bytes * 8;
  localparam int fifo_depth      = 16;
  localparam int fifo_addr_width = 4;

  // one captured match with the stamp in the low byte
  typedef struct packed {
    logic [15-num_rules-8:0] pad;   // always zero
    logic [num_rules-1:0]    rules;
    logic [7:0]              stamp;
  } event_t;

  // host register map with pattern and mask bytes decoded by range
  typedef enum logic [7:0] {
    reg_ctrl         = 8'h00,
    reg_rule_en      = 8'h01,
    reg_trig_en      = 8'h02,
    reg_trig_delay   = 8'h03,
    reg_trig_width   = 8'h04,
    reg_status       = 8'h05,
    reg_fifo_lo      = 8'h06,
    reg_fifo_hi      = 8'h07,
    reg_count0       = 8'h08,
    reg_count1       = 8'h09,
    reg_pattern_base = 8'h10,   // 0x10 + 4*rule + byte
    reg_mask_base    = 8'h20    // same layout as pattern
  } reg_addr_e;

  typedef enum logic [1:0] {
    trig_idle,
    trig_wait,
    trig_pulse
  } trig_state_e;

endpackage

`default_nettype wire

/* source/trace_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_regs import trace_pkg::*; (
  input  logic         fe_clk,
  input  logic         reset,
  input  reg_addr_e    reg_addr,
  input  logic [7:0]   reg_wdata,
  input  logic         reg_write,
  input  logic         reg_read,
  output logic [7:0]   reg_rdata,
  input  logic [7:0]   match_count [num_rules],
  input  event_t       fifo_head,
  input  logic         fifo_empty,
  input  logic         fifo_full,
  input  logic         fifo_overflow,
  input  logic         trig_busy,
  output logic         fifo_pop,
  trace_cfg_if.regs    cfg
);

  logic [7:0] addr;
  logic       in_pattern;
  logic       in_mask;
  logic       rule_sel;
  logic [4:0] bit_base;     // bit offset of the addressed byte
  logic [7:0] rd_value;

  assign addr       = reg_addr;
  assign in_pattern = ({addr[7:3], 3'b000} == reg_pattern_base);
  assign in_mask    = ({addr[7:3], 3'b000} == reg_mask_base);
  assign rule_sel   = addr[2];
  assign bit_base   = {addr[1:0], 3'b000};

  // pop happens on the same edge that returns the high byte
  assign fifo_pop = reg_read && (reg_addr == reg_fifo_hi) && !fifo_empty;

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      cfg.armed      <= 1'b0;
      cfg.arm_pulse  <= 1'b0;
      cfg.rule_en    <= '0;
      cfg.trig_en    <= '0;
      cfg.trig_delay <= '0;
      cfg.trig_width <= '0;
      for (int r = 0; r < num_rules; r++) begin
        cfg.pattern[r] <= '0;
        cfg.mask[r]    <= '0;
      end
    end else begin
      cfg.arm_pulse <= 1'b0;
      if (reg_write) begin
        case (reg_addr)
          reg_ctrl: begin
            cfg.armed     <= reg_wdata[0];
            cfg.arm_pulse <= reg_wdata[0];   // rearm restarts stamps
          end
          reg_rule_en:    cfg.rule_en    <= reg_wdata[num_rules-1:0];
          reg_trig_en:    cfg.trig_en    <= reg_wdata[num_rules-1:0];
          reg_trig_delay: cfg.trig_delay <= reg_wdata;
          reg_trig_width: cfg.trig_width <= reg_wdata;
          default: begin
            if (in_pattern)
              cfg.pattern[rule_sel][bit_base +: 8] <= reg_wdata;
            if (in_mask)
              cfg.mask[rule_sel][bit_base +: 8] <= reg_wdata;
          end
        endcase
      end
    end
  end

  always_comb begin
    rd_value = 8'h00;
    case (reg_addr)
      reg_ctrl:       rd_value = {7'b0, cfg.armed};
      reg_rule_en:    rd_value = {{(8-num_rules){1'b0}}, cfg.rule_en};
      reg_trig_en:    rd_value = {{(8-num_rules){1'b0}}, cfg.trig_en};
      reg_trig_delay: rd_value = cfg.trig_delay;
      reg_trig_width: rd_value = cfg.trig_width;
      reg_status:     rd_value = {4'b0, trig_busy, fifo_overflow, fifo_full, fifo_empty};
      reg_fifo_lo:    rd_value = fifo_empty ? 8'h00 : fifo_head[7:0];
      reg_fifo_hi:    rd_value = fifo_empty ? 8'h00 : fifo_head[15:8];
      reg_count0:     rd_value = match_count[0];
      reg_count1:     rd_value = match_count[1];
      default: begin
        if (in_pattern)
          rd_value = cfg.pattern[rule_sel][bit_base +: 8];
        else if (in_mask)
          rd_value = cfg.mask[rule_sel][bit_base +: 8];
      end
    endcase
  end

  // read data holds until the next read
  always_ff @(posedge fe_clk) begin
    if (reset)
      reg_rdata <= 8'h00;
    else if (reg_read)
      reg_rdata <= rd_value;
  end

  a_no_rw_collision: assert property (
    @(posedge fe_clk) disable iff (reset) !(reg_write && reg_read));

endmodule

`default_nettype wire

/* source/trace_top.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_top import trace_pkg::*; (
  input  logic       fe_clk,
  input  logic       reset,
  input  logic [7:0] reg_addr,
  input  logic [7:0] reg_wdata,
  input  logic       reg_write,
  input  logic       reg_read,
  output logic [7:0] reg_rdata,
  input  logic [7:0] trace_data,
  input  logic       trace_valid,
  output logic       capturing,
  output logic       trig_out
);

  logic [num_rules-1:0] match;
  logic                 byte_seen;
  logic [7:0]           match_count [num_rules];
  logic                 ev_write;
  event_t               ev_data;
  logic                 fifo_pop;
  event_t               fifo_head;
  logic                 fifo_empty;
  logic                 fifo_full;
  logic                 fifo_overflow;
  logic                 trig_busy;

  trace_cfg_if cfg ();

  assign capturing = cfg.armed;

  trace_regs u_regs (
    .fe_clk        (fe_clk),
    .reset         (reset),
    .reg_addr      (reg_addr_e'(reg_addr)),
    .reg_wdata     (reg_wdata),
    .reg_write     (reg_write),
    .reg_read      (reg_read),
    .reg_rdata     (reg_rdata),
    .match_count   (match_count),
    .fifo_head     (fifo_head),
    .fifo_empty    (fifo_empty),
    .fifo_full     (fifo_full),
    .fifo_overflow (fifo_overflow),
    .trig_busy     (trig_busy),
    .fifo_pop      (fifo_pop),
    .cfg           (cfg)
  );

  pattern_matcher u_matcher (
    .fe_clk      (fe_clk),
    .reset       (reset),
    .trace_data  (trace_data),
    .trace_valid (trace_valid),
    .cfg         (cfg),
    .match       (match),
    .byte_seen   (byte_seen),
    .match_count (match_count)
  );

  event_capture u_capture (
    .fe_clk    (fe_clk),
    .reset     (reset),
    .match     (match),
    .byte_seen (byte_seen),
    .cfg       (cfg),
    .ev_write  (ev_write),
    .ev_data   (ev_data)
  );

  event_fifo u_fifo (
    .fe_clk         (fe_clk),
    .reset          (reset),
    .ev_write       (ev_write),
    .ev_data        (ev_data),
    .pop            (fifo_pop),
    .clear_overflow (cfg.arm_pulse),
    .head           (fifo_head),
    .empty          (fifo_empty),
    .full           (fifo_full),
    .overflow       (fifo_overflow)
  );

  trigger_pulse u_trigger (
    .fe_clk   (fe_clk),
    .reset    (reset),
    .match    (match),
    .cfg      (cfg),
    .trig_out (trig_out),
    .busy     (trig_busy)
  );

endmodule

`default_nettype wire

/* source/trigger_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_pulse import trace_pkg::*; (
  input  logic                 fe_clk,
  input  logic                 reset,
  input  logic [num_rules-1:0] match,
  trace_cfg_if.trigger         cfg,
  output logic                 trig_out,
  output logic                 busy
);

  trig_state_e state;
  logic [7:0]  cnt;   // shared by delay and width

  assign busy = (state != trig_idle);

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      state    <= trig_idle;
      cnt      <= 8'h00;
      trig_out <= 1'b0;
    end else begin
      case (state)
        trig_idle: begin
          if (cfg.armed && (match & cfg.trig_en) != '0) begin
            state <= trig_wait;
            cnt   <= cfg.trig_delay;
          end
        end
        trig_wait: begin
          if (cnt == 8'h00) begin
            state    <= trig_pulse;
            trig_out <= 1'b1;
            cnt      <= (cfg.trig_width == 8'h00) ? 8'h00 : cfg.trig_width - 8'd1;
          end else
            cnt <= cnt - 8'd1;
        end
        trig_pulse: begin
          if (cnt == 8'h00) begin
            state    <= trig_idle;
            trig_out <= 1'b0;
          end else
            cnt <= cnt - 8'd1;
        end
        default: state <= trig_idle;
      endcase
    end
  end

  a_out_in_pulse: assert property (
    @(posedge fe_clk) disable iff (reset) trig_out |-> state == trig_pulse);

endmodule

`default_nettype wire

/* verif/tb_trace_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_trace_top;

  logic       fe_clk;
  logic       reset;
  logic [7:0] reg_addr;
  logic [7:0] reg_wdata;
  logic       reg_write;
  logic       reg_read;
  logic [7:0] reg_rdata;
  logic [7:0] trace_data;
  logic       trace_valid;
  logic       capturing;
  logic       trig_out;

  int    seed = 65165;
  int    value_errs = 0;
  int    other_errs = 0;
  int    limit_cycles = 0;   // set once the tests file is loaded
  string lines [$];

  trace_top DUT (
    .fe_clk      (fe_clk),
    .reset       (reset),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_write   (reg_write),
    .reg_read    (reg_read),
    .reg_rdata   (reg_rdata),
    .trace_data  (trace_data),
    .trace_valid (trace_valid),
    .capturing   (capturing),
    .trig_out    (trig_out)
  );

  always #10 fe_clk = ~fe_clk;

  // every task starts and ends just after a falling edge
  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    reg_addr  = addr;
    reg_wdata = data;
    reg_write = 1'b1;
    @(negedge fe_clk);
    reg_write = 1'b0;
  endtask

  task automatic read_reg(input string name, input logic [7:0] addr, input logic [7:0] exp);
    reg_addr = addr;
    reg_read = 1'b1;
    @(negedge fe_clk);
    reg_read = 1'b0;
    if (reg_rdata !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, reg_rdata);
      value_errs++;
    end
    // armed bit of ctrl is also visible on the capturing pin
    if (addr == 8'h00 && capturing !== exp[0]) begin
      $display("ERR %s capturing: expected %b, actual %b", name, exp[0], capturing);
      value_errs++;
    end
  endtask

  task automatic send_byte(input logic [7:0] data);
    trace_data  = data;
    trace_valid = 1'b1;
    @(negedge fe_clk);
    trace_valid = 1'b0;
  endtask

  task automatic random_burst(input int count);
    logic [31:0] rnd;
    for (int k = 0; k < count; k++) begin
      rnd = $random(seed);
      send_byte((rnd[7:0] == 8'h3c) ? 8'hc3 : rnd[7:0]);   // keep clear of the rule 0 marker
    end
  endtask

  task automatic read_events(input string name, input logic [7:0] first, input int count,
                             input logic [7:0] hi);
    for (int k = 0; k < count; k++) begin
      read_reg(name, 8'h06, first + k[7:0]);   // stamps run on from the first one
      read_reg(name, 8'h07, hi);
    end
  endtask

  task automatic check_trigger(input string name, input logic [7:0] data, input int delay,
                               input int width, input logic again, input int pulses_exp);
    int   width_exp;
    int   window;
    int   rise_at;
    int   high_cnt;
    int   pulses;
    logic prev;
    width_exp = (width == 0) ? 1 : width;
    window    = delay + width_exp + 12;
    rise_at   = -1;
    high_cnt  = 0;
    pulses    = 0;
    prev      = 1'b0;
    trace_data  = data;
    trace_valid = 1'b1;
    @(negedge fe_clk);
    trace_valid = again;   // repeat match while the FSM is busy
    for (int k = 1; k <= window; k++) begin
      @(negedge fe_clk);
      trace_valid = 1'b0;
      if (trig_out && !prev) begin
        pulses++;
        if (rise_at < 0)
          rise_at = k;
      end
      if (trig_out)
        high_cnt++;
      prev = trig_out;
    end
    if (pulses != pulses_exp) begin
      $display("ERR %s pulses: expected %0d, actual %0d", name, pulses_exp, pulses);
      value_errs++;
    end else if (pulses_exp == 1) begin
      if (rise_at != delay + 3) begin
        $display("ERR %s rise edge: expected %0d, actual %0d", name, delay + 3, rise_at);
        value_errs++;
      end
      if (high_cnt != width_exp) begin
        $display("ERR %s width: expected %0d, actual %0d", name, width_exp, high_cnt);
        value_errs++;
      end
    end
  endtask

  task automatic run_line(input string line);
    string       op;
    string       name;
    logic [31:0] arg [5];
    int          n;
    n = $sscanf(line, "%s %s %h %h %h %h %h", op, name, arg[0], arg[1], arg[2], arg[3],
                arg[4]);
    case (op)
      "w": write_reg(arg[0][7:0], arg[1][7:0]);
      "r": read_reg(name, arg[0][7:0], arg[1][7:0]);
      "t": send_byte(arg[0][7:0]);
      "i": repeat (arg[0]) @(negedge fe_clk);
      "b": random_burst(arg[0]);
      "e": read_events(name, arg[0][7:0], arg[1], arg[2][7:0]);
      "g": check_trigger(name, arg[0][7:0], arg[1], arg[2], arg[3][0], arg[4]);
      default: begin
        $display("unknown operation (%0d fields) in tests file line: %s", n, line);
        other_errs++;
      end
    endcase
  endtask

  initial begin
    int    fd;
    string line;
    fe_clk      = 1'b0;
    reset       = 1'b1;
    reg_addr    = 8'h00;
    reg_wdata   = 8'h00;
    reg_write   = 1'b0;
    reg_read    = 1'b0;
    trace_data  = 8'h00;
    trace_valid = 1'b0;
    fd = $fopen("verif/trace_tests.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#")
          lines.push_back(line);
      end
      $fclose(fd);
    end
    repeat (8) @(posedge fe_clk);
    @(negedge fe_clk);
    reset = 1'b0;
    if (fd == 0) begin
      $display("could not open the tests file verif/trace_tests.txt");
      other_errs++;
    end else if (lines.size() == 0) begin
      $display("the tests file holds no operations");
      other_errs++;
    end else begin
      limit_cycles = lines.size() * 300;
      foreach (lines[i])
        run_line(lines[i]);
    end
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog scaled by the number of operations
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge fe_clk);
    $display("run did not finish within %0d cycles", limit_cycles);
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs + 1);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/trace_tests.txt */
# columns: op name then hex args. w addr data, r addr expected, t byte, i cycles, b count
# e first_stamp count hi_byte, g byte delay width again pulses (again 1 = repeat byte)
r rst_status 05 01
r rst_count0 08 00
r rst_count1 09 00
r rst_ctrl 00 00
w pat0_b0 10 3c
w pat0_b1 11 a5
w msk0_b0 20 ff
w msk0_b1 21 f0
w trig_delay 03 02
w trig_width 04 03
r pat0_b1_rd 11 a5
r msk0_b1_rd 21 f0
r delay_rd 03 02
r width_rd 04 03
w rule0_on 01 01
t m1_a ab
t m1_b 3c
t m2_a a0
t m2_b 3c
t nomatch 3c
i settle 3
r cnt0_two 08 02
r cnt1_off 09 00
w rules_on 01 03
t any_byte 00
i settle 3
r cnt1_one 09 01
b sat_burst 12c
i settle 3
r cnt1_sat 09 ff
r cnt0_hold 08 02
w rule0_only 01 01
w arm 00 01
t c1 11
t c2 a1
t c3 3c
t c4 af
t c5 3c
i settle 3
r armed_rd 00 01
r ev1_lo 06 03
r ev1_hi 07 01
r ev2_lo 06 05
r ev2_hi 07 01
r cap_empty 05 01
w rules_on2 01 03
w rearm 00 01
b ovf_burst 14
i settle 3
r ovf_status 05 06
e ovf_events 01 10 02
r ovf_drained 05 05
w arm_again 00 01
t st1 11
i settle 3
r st_status 05 00
r st_lo 06 01
r st_hi 07 02
w rule0_trig 01 01
w msk0_b1_off 21 00
w trig_rule0 02 01
g trig_d2w3 3c 02 03 0 1
w width0 04 00
g trig_w0_busy 3c 02 00 1 1
w disarm 00 00
g trig_unarmed 3c 02 00 0 0
